// File: design/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // fixed bus widths
    localparam int BITS_PER_WORD   = 32;
    localparam int IBUS_DATA_WIDTH = 64;
    localparam int CBUS_DATA_WIDTH = 32;
    localparam int CBUS_DATA_BYTES = 4;
    localparam int CBUS_ORDER_BITS = 4;

    typedef logic [BITS_PER_WORD-1:0]   word_t;
    typedef logic [IBUS_DATA_WIDTH-1:0] ibus_data_t;
    typedef logic [CBUS_DATA_WIDTH-1:0] cbus_data_t;

    // log2 of burst length in beats
    typedef logic [CBUS_ORDER_BITS-1:0] cbus_order_t;

    typedef struct packed {
        logic as_index;
        logic invalidate;
    } cache_funct_t;

    typedef struct packed {
        logic         req;
        cache_funct_t funct;
    } cache_op_t;

    typedef struct packed {
        logic      req;
        word_t     addr;
        cache_op_t cache_op;
    } ibus_req_t;

    typedef struct packed {
        logic       addr_ok;
        logic       data_ok;
        ibus_data_t data;
        // which 32-bit half of the bundle was asked for
        logic       index;
    } ibus_resp_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        word_t       addr;
        cbus_order_t order;
        cbus_data_t  wdata;
    } cbus_req_t;

    typedef struct packed {
        logic       okay;
        logic       last;
        cbus_data_t rdata;
    } cbus_resp_t;

endpackage

`default_nettype wire

// File: design/meta_ram.sv
`timescale 1ns/1ps
`default_nettype none

module meta_ram #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out
);
    localparam int NUM_ROWS = 2**ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] rows [NUM_ROWS];
    logic [ADDR_WIDTH-1:0] addr_q;

    // row picked by the address of the previous cycle
    assign data_out = rows[addr_q];

    always_ff @(posedge clk) begin
        if (resetn) begin
            addr_q <= '0;
            for (int i = 0; i < NUM_ROWS; i++) begin
                rows[i] <= '0;
            end
        end else begin
            addr_q       <= addr;
            // read-modify-write of the row being looked at
            rows[addr_q] <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: design/plru_tree.sv
`timescale 1ns/1ps
`default_nettype none

module plru_tree #(
    parameter int NUM_WAYS = 4
) (
    input  logic [NUM_WAYS-2:0]         select,
    input  logic [$clog2(NUM_WAYS)-1:0] idx,
    output logic [$clog2(NUM_WAYS)-1:0] victim_idx,
    output logic [NUM_WAYS-2:0]         new_select
);
    localparam int LEVELS = $clog2(NUM_WAYS);

    // node n has children 2n+1 (bit low) and 2n+2 (bit high)

    // walk down the tree along the select bits
    always_comb begin
        int node;

        node       = 0;
        victim_idx = '0;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            victim_idx[LEVELS-1-lvl] = select[node];
            node = 2 * node + 1 + int'(select[node]);
        end
    end

    // walk down the path to idx, pointing each node the other way
    always_comb begin
        int   node;
        logic dir;

        node       = 0;
        new_select = select;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            dir              = idx[LEVELS-1-lvl];
            new_select[node] = ~dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

endmodule

`default_nettype wire

// File: design/line_bram.sv
`timescale 1ns/1ps
`default_nettype none

module line_bram #(
    parameter int  ADDR_WIDTH = 6,
    localparam int NUM_BYTES  = $bits(icache_pkg::ibus_data_t) / 8
) (
    input  logic                   clk,

    // read port
    input  logic [ADDR_WIDTH-1:0]  addr_1,
    output icache_pkg::ibus_data_t data_out_1,

    // byte-write port
    input  logic [NUM_BYTES-1:0]   write_en_2,
    input  logic [ADDR_WIDTH-1:0]  addr_2,
    input  icache_pkg::ibus_data_t data_in_2
);
    localparam int DEPTH = 2**ADDR_WIDTH;

    icache_pkg::ibus_data_t mem [DEPTH];

    // read-first: a same-cycle write to addr_1 shows up one read later
    always_ff @(posedge clk) begin
        data_out_1 <= mem[addr_1];
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (write_en_2[b]) begin
                mem[addr_2][8*b +: 8] <= data_in_2[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int IDX_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::word_t      ibus_vaddr,
    input  icache_pkg::ibus_req_t  ibus_req,
    output icache_pkg::ibus_resp_t ibus_resp,
    output icache_pkg::cbus_req_t  cbus_req,
    input  icache_pkg::cbus_resp_t cbus_resp
);
    localparam int DATA_BYTES      = $bits(icache_pkg::ibus_data_t) / 8;
    localparam int ALIGN_BITS      = $clog2(DATA_BYTES);
    localparam int CBUS_ALIGN_BITS = $clog2(icache_pkg::CBUS_DATA_BYTES);
    localparam int SHAMT_BITS      = ALIGN_BITS - CBUS_ALIGN_BITS;
    localparam int WIDTH_RATIO     = DATA_BYTES / icache_pkg::CBUS_DATA_BYTES;
    localparam int LINE_LENGTH     = 2**OFFSET_BITS;
    localparam int NUM_WAYS        = 2**IDX_BITS;
    localparam int COUNT_BITS      = OFFSET_BITS + SHAMT_BITS;
    localparam int READY_BITS      = 2**COUNT_BITS;
    localparam int NONTAG_BITS     = INDEX_BITS + OFFSET_BITS + ALIGN_BITS;
    localparam int TAG_BITS        = $bits(icache_pkg::word_t) - NONTAG_BITS;
    localparam int MEM_ADDR_BITS   = IDX_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [INDEX_BITS-1:0]      index_t;
    typedef logic [OFFSET_BITS-1:0]     offset_t;
    typedef logic [SHAMT_BITS-1:0]      shamt_t;
    typedef logic [CBUS_ALIGN_BITS-1:0] zeros_t;
    typedef logic [IDX_BITS-1:0]        idx_t;
    typedef logic [NUM_WAYS-1:0]        way_mask_t;
    typedef logic [NUM_WAYS-2:0]        select_t;
    typedef logic [DATA_BYTES-1:0]      byte_en_t;
    typedef logic [READY_BITS-1:0]      ready_t;
    typedef tag_t [NUM_WAYS-1:0]        way_tags_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
        shamt_t  shamt;
        zeros_t  zeros;
    } addr_t;

    // beat position inside a line
    typedef struct packed {
        offset_t offset;
        shamt_t  shamt;
    } count_t;

    // line_bram address
    typedef struct packed {
        idx_t    idx;
        index_t  index;
        offset_t offset;
    } iaddr_t;

    localparam byte_en_t MISS_MASK = {
        {(DATA_BYTES - icache_pkg::CBUS_DATA_BYTES){1'b0}},
        {icache_pkg::CBUS_DATA_BYTES{1'b1}}
    };

    addr_t                 req_vaddr;
    addr_t                 req_paddr;
    icache_pkg::cache_op_t cop;
    logic                  fetch_req;

    assign req_vaddr = ibus_vaddr;
    assign req_paddr = ibus_req.addr;
    assign cop.req   = ibus_req.req && ibus_req.cache_op.req;
    assign cop.funct = ibus_req.cache_op.funct;
    assign fetch_req = ibus_req.req && !ibus_req.cache_op.req;

    // per-set valid bits, tags and plru select bits
    way_mask_t ram_valid, ram_new_valid;
    way_tags_t ram_tags, ram_new_tags;
    select_t   ram_select, ram_new_select;

    meta_ram #(.DATA_WIDTH($bits(way_mask_t)), .ADDR_WIDTH(INDEX_BITS)) valid_ram_i (
        .clk(clk), .resetn(resetn), .addr(req_vaddr.index),
        .data_in(ram_new_valid), .data_out(ram_valid)
    );
    meta_ram #(.DATA_WIDTH($bits(way_tags_t)), .ADDR_WIDTH(INDEX_BITS)) tag_ram_i (
        .clk(clk), .resetn(resetn), .addr(req_vaddr.index),
        .data_in(ram_new_tags), .data_out(ram_tags)
    );
    meta_ram #(.DATA_WIDTH($bits(select_t)), .ADDR_WIDTH(INDEX_BITS)) select_ram_i (
        .clk(clk), .resetn(resetn), .addr(req_vaddr.index),
        .data_in(ram_new_select), .data_out(ram_select)
    );

    // hit test over all ways and the number of the hit way
    way_mask_t req_hit_bits;
    logic      req_hit;
    idx_t      req_idx;

    for (genvar i = 0; i < NUM_WAYS; i++) begin : g_hit
        assign req_hit_bits[i] = ram_valid[i] && (ram_tags[i] == req_paddr.tag);
    end
    assign req_hit = |req_hit_bits;

    always_comb begin
        req_idx = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (req_hit_bits[i]) begin
                req_idx = req_idx | idx_t'(i);
            end
        end
    end

    idx_t    req_victim_idx;
    select_t req_new_select;

    plru_tree #(.NUM_WAYS(NUM_WAYS)) plru_i (
        .select(ram_select), .idx(req_idx),
        .victim_idx(req_victim_idx), .new_select(req_new_select)
    );

    // miss stage
    logic     miss_busy;
    tag_t     miss_tag;
    index_t   miss_index;
    idx_t     miss_way;
    count_t   miss_count;
    ready_t   miss_mark;
    logic     miss_avail;
    byte_en_t miss_write_en;
    iaddr_t   miss_pos;
    addr_t    miss_line_addr;

    logic [LINE_LENGTH-1:0]   miss_bundle_ready;
    icache_pkg::ibus_data_t   miss_wdata;

    // fill idle now or free again after this beat
    assign miss_avail    = !miss_busy || cbus_resp.last;
    assign miss_write_en = cbus_resp.okay ?
        byte_en_t'(MISS_MASK << (miss_count.shamt * icache_pkg::CBUS_DATA_BYTES)) : '0;
    assign miss_wdata    = {WIDTH_RATIO{cbus_resp.rdata}};

    assign miss_pos.idx    = miss_way;
    assign miss_pos.index  = miss_index;
    assign miss_pos.offset = miss_count.offset;

    // a bundle is usable once all of its beats have landed
    for (genvar i = 0; i < LINE_LENGTH; i++) begin : g_bundle_ready
        assign miss_bundle_ready[i] = &miss_mark[i*WIDTH_RATIO +: WIDTH_RATIO];
    end

    logic req_in_miss, req_miss_ready;
    logic req_to_hit, req_to_miss;

    assign req_in_miss    = miss_busy && (req_paddr.tag == miss_tag) &&
                            (req_vaddr.index == miss_index);
    assign req_miss_ready = !req_in_miss || miss_bundle_ready[req_vaddr.offset];
    assign req_to_hit     = fetch_req && req_hit && req_miss_ready;
    assign req_to_miss    = fetch_req && !req_hit && miss_avail;

    // line data
    iaddr_t                 hit_pos;
    icache_pkg::ibus_data_t hit_data;

    assign hit_pos.idx    = req_idx;
    assign hit_pos.index  = req_vaddr.index;
    assign hit_pos.offset = req_vaddr.offset;

    line_bram #(.ADDR_WIDTH(MEM_ADDR_BITS)) line_bram_i (
        .clk(clk),
        .addr_1(hit_pos), .data_out_1(hit_data),
        .write_en_2(miss_write_en), .addr_2(miss_pos), .data_in_2(miss_wdata)
    );

    // cache operations run only between fills
    logic cop_ready;
    logic cop_way_ok;
    idx_t cop_idx;

    assign cop_ready  = cop.req && !miss_busy;
    assign cop_idx    = cop.funct.as_index ? idx_t'(req_vaddr.tag) : req_idx;
    // hit-based ops do nothing on a miss
    assign cop_way_ok = cop.funct.as_index || req_hit;

    // metadata write-back
    assign ram_new_select = req_to_hit ? req_new_select : ram_select;

    always_comb begin
        ram_new_valid = ram_valid;
        ram_new_tags  = ram_tags;
        if (cop_ready) begin
            if (cop.funct.invalidate && cop_way_ok) begin
                ram_new_valid[cop_idx] = 1'b0;
            end
        end else if (req_to_miss) begin
            ram_new_valid[req_victim_idx] = 1'b1;
            ram_new_tags[req_victim_idx]  = req_paddr.tag;
        end
    end

    logic hit_data_ok;
    logic hit_resp_index;

    always_ff @(posedge clk) begin
        if (resetn) begin
            hit_data_ok    <= 1'b0;
            hit_resp_index <= 1'b0;
            miss_busy      <= 1'b0;
            miss_count     <= '0;
            miss_mark      <= '0;
        end else begin
            hit_data_ok    <= req_to_hit || cop_ready;
            hit_resp_index <= req_paddr.shamt;
            miss_busy      <= miss_avail ? req_to_miss : 1'b1;

            if (cbus_resp.okay) begin
                miss_mark[miss_count] <= 1'b1;
                miss_count            <= count_t'(miss_count + 1'b1);
            end
            // new fill starts at the first beat of the line
            if (req_to_miss) begin
                miss_count <= '0;
                miss_mark  <= '0;
            end
        end
    end

    // line being filled
    always_ff @(posedge clk) begin
        if (req_to_miss) begin
            miss_tag   <= req_paddr.tag;
            miss_index <= req_vaddr.index;
            miss_way   <= req_victim_idx;
        end
    end

    assign miss_line_addr.tag    = miss_tag;
    assign miss_line_addr.index  = miss_index;
    assign miss_line_addr.offset = '0;
    assign miss_line_addr.shamt  = '0;
    assign miss_line_addr.zeros  = '0;

    // instruction bus
    assign ibus_resp.addr_ok = cop.req ? !miss_busy : (fetch_req && req_hit && req_miss_ready);
    assign ibus_resp.data_ok = hit_data_ok;
    assign ibus_resp.data    = hit_data;
    assign ibus_resp.index   = hit_resp_index;

    // cache bus carries an incrementing burst over one line
    assign cbus_req.valid    = miss_busy;
    assign cbus_req.is_write = 1'b0;
    assign cbus_req.addr     = miss_line_addr;
    assign cbus_req.order    = icache_pkg::cbus_order_t'(COUNT_BITS);
    assign cbus_req.wdata    = '0;

endmodule

`default_nettype wire

// File: design/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    // 4 ways, 4 sets, 4 bundles per line
    parameter int IDX_BITS    = 2,
    parameter int INDEX_BITS  = 2,
    parameter int OFFSET_BITS = 2
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::word_t      ibus_vaddr,
    input  icache_pkg::ibus_req_t  ibus_req,
    output icache_pkg::ibus_resp_t ibus_resp,
    output icache_pkg::cbus_req_t  cbus_req,
    input  icache_pkg::cbus_resp_t cbus_resp
);

    icache #(
        .IDX_BITS   (IDX_BITS),
        .INDEX_BITS (INDEX_BITS),
        .OFFSET_BITS(OFFSET_BITS)
    ) icache_i (
        .clk       (clk),
        .resetn    (resetn),
        .ibus_vaddr(ibus_vaddr),
        .ibus_req  (ibus_req),
        .ibus_resp (ibus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

endmodule

`default_nettype wire

// File: dv/cbus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module cbus_mem_model #(
    parameter icache_pkg::word_t PATTERN_KEY = 32'h5a5a0000
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::cbus_req_t  cbus_req,
    output icache_pkg::cbus_resp_t cbus_resp
);
    integer            seed = 32'h8b58;
    logic              active = 1'b0;
    icache_pkg::word_t base = '0;
    int                beat = 0;
    int                num_beats = 0;
    int                gap = 0;

    // pattern word for a byte address with the low two bits dropped
    function automatic icache_pkg::cbus_data_t word_at(input icache_pkg::word_t a);
        return {a[31:2], 2'b00} ^ PATTERN_KEY;
    endfunction

    initial begin
        cbus_resp = '0;
    end

    // at most one beat per cycle and 0 to 2 idle cycles between beats
    always @(negedge clk) begin
        cbus_resp = '0;
        if (resetn) begin
            active = 1'b0;
        end else begin
            if (!active && cbus_req.valid) begin
                active    = 1'b1;
                base      = cbus_req.addr;
                beat      = 0;
                num_beats = 1 << cbus_req.order;
                gap       = $unsigned($random(seed)) % 3;
            end
            if (active) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    cbus_resp.okay  = 1'b1;
                    cbus_resp.rdata = word_at(base + icache_pkg::word_t'(beat * 4));
                    cbus_resp.last  = (beat == num_beats - 1);
                    beat = beat + 1;
                    if (cbus_resp.last) begin
                        active = 1'b0;
                    end else begin
                        gap = $unsigned($random(seed)) % 3;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int                CLK_PERIOD      = 40;
    localparam int                CYCLES_PER_STEP = 60;
    localparam icache_pkg::word_t PATTERN_KEY     = 32'h5a5a0000;

    // 4 bundles of two 32-bit beats per line
    localparam int BURST_ORDER = 3;
    localparam int LINE_BYTES  = 4 << BURST_ORDER;

    // step kinds as read from the golden file
    localparam logic [63:0] KIND_FETCH   = {24'h0, "fetch"};
    localparam logic [63:0] KIND_COP     = {40'h0, "cop"};
    localparam logic [63:0] KIND_IDLE    = {32'h0, "idle"};
    localparam logic [63:0] KIND_COMMENT = {56'h0, "#"};

    logic                   clk = 1'b0;
    logic                   resetn;
    icache_pkg::word_t      ibus_vaddr;
    icache_pkg::ibus_req_t  ibus_req;
    icache_pkg::ibus_resp_t ibus_resp;
    icache_pkg::cbus_req_t  cbus_req;
    icache_pkg::cbus_resp_t cbus_resp;

    logic [63:0]            step_kind [$];
    icache_pkg::word_t      step_addr [$];
    logic [1:0]             step_op [$];
    icache_pkg::ibus_data_t step_data [$];
    int                     step_refills [$];

    int                mismatches = 0;
    int                other_errors = 0;
    int                cycles = 0;
    int                cycle_limit = 0;
    int                refills = 0;
    int                requests = 0;
    int                data_oks = 0;
    logic              fill_open = 1'b0;
    logic              accept_q = 1'b0;
    icache_pkg::word_t burst_addr = '0;

    icache_top icache_top_i (
        .clk       (clk),
        .resetn    (resetn),
        .ibus_vaddr(ibus_vaddr),
        .ibus_req  (ibus_req),
        .ibus_resp (ibus_resp),
        .cbus_req  (cbus_req),
        .cbus_resp (cbus_resp)
    );

    cbus_mem_model #(.PATTERN_KEY(PATTERN_KEY)) mem_i (
        .clk      (clk),
        .resetn   (resetn),
        .cbus_req (cbus_req),
        .cbus_resp(cbus_resp)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // a refill starts when valid is seen outside a running burst
    always @(posedge clk) begin
        if (resetn) begin
            fill_open <= 1'b0;
        end else begin
            if (cbus_req.valid) begin
                verify_burst_req();
            end
            if (cbus_req.valid && !fill_open) begin
                refills <= refills + 1;
            end
            fill_open  <= cbus_req.valid && !(cbus_resp.okay && cbus_resp.last);
            burst_addr <= cbus_req.addr;
        end
    end

    // data_ok must follow each accept by exactly one cycle
    always @(posedge clk) begin
        if (resetn) begin
            accept_q <= 1'b0;
        end else begin
            assert (ibus_resp.data_ok == accept_q) else begin
                $display("Mismatch data_ok after accept: expected %b, actual %b",
                         accept_q, ibus_resp.data_ok);
                mismatches++;
            end
            accept_q <= ibus_req.req && ibus_resp.addr_ok;
            if (ibus_resp.data_ok) begin
                data_oks++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run timed out after %0d cycles without finishing the steps", cycles);
            print_counts();
            $display("test failed");
            $finish;
        end
    end

    task automatic print_counts();
        $display("steps %0d, requests %0d, refills %0d, mismatches %0d, other errors %0d",
                 step_kind.size(), requests, refills, mismatches, other_errors);
    endtask

    // read-only burst over one whole line, address held until the last beat
    task automatic verify_burst_req();
        assert (!cbus_req.is_write) else begin
            $display("Mismatch cbus is_write: expected 0, actual %b", cbus_req.is_write);
            mismatches++;
        end
        assert (cbus_req.order == BURST_ORDER) else begin
            $display("Mismatch cbus order: expected %0d, actual %0d",
                     BURST_ORDER, cbus_req.order);
            mismatches++;
        end
        assert (cbus_req.addr % LINE_BYTES == 0) else begin
            $display("cbus address %h is not aligned to a line", cbus_req.addr);
            other_errors++;
        end
        if (fill_open) begin
            assert (cbus_req.addr == burst_addr) else begin
                $display("Mismatch cbus addr in burst: expected %h, actual %h",
                         burst_addr, cbus_req.addr);
                mismatches++;
            end
        end
    endtask

    task automatic load_golden();
        int                     fd;
        int                     n;
        logic [63:0]            kind;
        icache_pkg::word_t      addr;
        logic [1:0]             op;
        icache_pkg::ibus_data_t data;
        int                     refill_count;
        logic [8*128-1:0]       rest;

        fd = $fopen("dv/icache_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file dv/icache_golden.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            kind = '0;
            n = $fscanf(fd, "%s", kind);
            if (n != 1) begin
                break;
            end
            if (kind == KIND_COMMENT) begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %d", addr, op, data, refill_count);
                if (n != 4) begin
                    $display("golden line %0d is malformed", step_kind.size() + 1);
                    other_errors++;
                    break;
                end
                step_kind.push_back(kind);
                step_addr.push_back(addr);
                step_op.push_back(op);
                step_data.push_back(data);
                step_refills.push_back(refill_count);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_quiet();
        assert (!ibus_resp.addr_ok) else begin
            $display("Mismatch reset addr_ok: expected 0, actual %b", ibus_resp.addr_ok);
            mismatches++;
        end
        assert (!ibus_resp.data_ok) else begin
            $display("Mismatch reset data_ok: expected 0, actual %b", ibus_resp.data_ok);
            mismatches++;
        end
        assert (!cbus_req.valid) else begin
            $display("Mismatch reset cbus valid: expected 0, actual %b", cbus_req.valid);
            mismatches++;
        end
    endtask

    // present vaddr one cycle ahead and hold the request until addr_ok
    task automatic issue_request(
        input  icache_pkg::word_t        addr,
        input  logic                     is_cop,
        input  icache_pkg::cache_funct_t funct,
        output icache_pkg::ibus_data_t   data,
        output logic                     half
    );
        logic accepted;

        @(negedge clk);
        ibus_vaddr = addr;
        ibus_req   = '0;
        @(negedge clk);
        ibus_req.req                = 1'b1;
        ibus_req.addr               = addr;
        ibus_req.cache_op.req       = is_cop;
        ibus_req.cache_op.funct     = funct;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = ibus_resp.addr_ok;
        end
        requests++;
        @(negedge clk);
        ibus_req = '0;
        @(posedge clk);
        assert (ibus_resp.data_ok) else begin
            $display("no data_ok in the cycle after the request at %h was accepted", addr);
            other_errors++;
        end
        data = ibus_resp.data;
        half = ibus_resp.index;
    endtask

    task automatic wait_fill_idle();
        @(posedge clk);
        while (cbus_req.valid) begin
            @(posedge clk);
        end
    endtask

    task automatic run_step(input int i);
        string                    name;
        icache_pkg::ibus_data_t   data;
        logic                     half;
        icache_pkg::cache_funct_t funct;

        funct = icache_pkg::cache_funct_t'(step_op[i]);
        if (step_kind[i] == KIND_FETCH) begin
            name = $sformatf("step %0d fetch %h", i + 1, step_addr[i]);
            issue_request(step_addr[i], 1'b0, funct, data, half);
            assert (data === step_data[i]) else begin
                $display("Mismatch %s data: expected %h, actual %h", name, step_data[i], data);
                mismatches++;
            end
            assert (half === step_addr[i][2]) else begin
                $display("Mismatch %s index: expected %b, actual %b",
                         name, step_addr[i][2], half);
                mismatches++;
            end
        end else if (step_kind[i] == KIND_COP) begin
            name = $sformatf("step %0d cop %h op %h", i + 1, step_addr[i], step_op[i]);
            issue_request(step_addr[i], 1'b1, funct, data, half);
        end else if (step_kind[i] == KIND_IDLE) begin
            name = $sformatf("step %0d idle", i + 1);
            wait_fill_idle();
        end else begin
            name = $sformatf("step %0d", i + 1);
            $display("golden step %0d has an unknown kind", i + 1);
            other_errors++;
        end
        assert (refills == step_refills[i]) else begin
            $display("Mismatch %s refills: expected %0d, actual %0d",
                     name, step_refills[i], refills);
            mismatches++;
        end
    endtask

    initial begin
        ibus_vaddr = '0;
        ibus_req   = '0;
        resetn     = 1'b1;
        load_golden();
        cycle_limit = CYCLES_PER_STEP * step_kind.size() + 16;

        repeat (4) @(negedge clk);
        resetn = 1'b0;

        repeat (2) begin
            @(posedge clk);
            check_quiet();
        end

        for (int i = 0; i < step_kind.size(); i++) begin
            run_step(i);
        end

        @(negedge clk);
        assert (data_oks == requests) else begin
            $display("requests %0d and data_ok pulses %0d do not agree", requests, data_oks);
            other_errors++;
        end
        print_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/icache_pkg.sv
design/meta_ram.sv
design/plru_tree.sv
design/line_bram.sv
design/icache.sv
design/icache_top.sv
dv/cbus_mem_model.sv
dv/icache_tb.sv

// File: dv/icache_golden.txt
# kind addr(hex) op(hex, bit1 as_index, bit0 invalidate) bundle(hex) refills(dec)
# bundle is {word(b+4), word(b)} for b the 8-aligned address, word(a) = a ^ 5a5a0000
fetch 00001000 0 5a5a10045a5a1000 1
fetch 00001018 0 5a5a101c5a5a1018 1
fetch 0000100c 0 5a5a100c5a5a1008 1
fetch 00001014 0 5a5a10145a5a1010 1
fetch 00002020 0 5a5a20245a5a2020 2
fetch 00003028 0 5a5a302c5a5a3028 3
fetch 00004030 0 5a5a40345a5a4030 4
fetch 00005038 0 5a5a503c5a5a5038 5
fetch 00006024 0 5a5a60245a5a6020 6
fetch 00002020 0 5a5a20245a5a2020 7
fetch 00004030 0 5a5a40345a5a4030 7
fetch 00003028 0 5a5a302c5a5a3028 8
idle 00000000 0 0000000000000000 8
fetch 00005038 0 5a5a503c5a5a5038 9
cop 00004020 1 0000000000000000 9
fetch 00004030 0 5a5a40345a5a4030 10
cop 000001a0 3 0000000000000000 10
fetch 0000302c 0 5a5a302c5a5a3028 11
fetch 00005038 0 5a5a503c5a5a5038 11
cop 00000020 2 0000000000000000 11
cop 00007020 1 0000000000000000 11
fetch 00001008 0 5a5a100c5a5a1008 11
cop 00001000 1 0000000000000000 11
fetch 00001010 0 5a5a10145a5a1010 12
idle 00000000 0 0000000000000000 12
fetch 00001004 0 5a5a10045a5a1000 12
